//--- blit_datapath.sv
`default_nettype none

module blit_datapath (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire blit_pkg::blit_cfg_t     cfg_i,
    input  wire logic                    setup_i,
    input  wire logic                    capture_i,
    input  wire blit_pkg::word_t         vram_data_i,
    input  wire logic                    first_word_i,
    input  wire logic                    last_word_i,
    output      blit_pkg::word_t         data_o,
    output      logic [blit_pkg::NIBS-1:0] wr_mask_o
);

    localparam int PREV_W = blit_pkg::WORD_W - blit_pkg::NIB_W;    // nibbles carried to next word

    blit_pkg::word_t           val_s_q;                 // shifted source or constant
    logic [PREV_W-1:0]         prev_q;                  // low nibbles of last source word
    logic                      load_q;                  // active cfg just became valid
    logic [blit_pkg::NIBS-1:0] f_sel;
    logic [blit_pkg::NIBS-1:0] l_sel;
    logic [blit_pkg::NIBS-1:0] t_mask;

    // right shift by whole nibbles, previous word's low nibbles fill from the top
    function automatic blit_pkg::word_t nib_shift(
        input logic [1:0]        amt,
        input blit_pkg::word_t   cur,
        input logic [PREV_W-1:0] prev
    );
        logic [PREV_W+blit_pkg::WORD_W-1:0] joined;
        logic [PREV_W+blit_pkg::WORD_W-1:0] shifted;
        joined  = {prev, cur};
        shifted = joined >> (amt * blit_pkg::NIB_W);
        return shifted[blit_pkg::WORD_W-1:0];
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            load_q <= 1'b0;
        end else begin
            load_q <= setup_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load_q) begin
            val_s_q <= cfg_i.src_s;                     // the constant when s_const
            prev_q  <= '0;                              // no carry into a new blit
        end else if (capture_i) begin
            val_s_q <= nib_shift(cfg_i.shift_amt, vram_data_i, prev_q);
            prev_q  <= vram_data_i[PREV_W-1:0];
        end
    end

    // odd nibbles match transp_t high half, even nibbles the low half
    always_comb begin
        for (int i = 0; i < blit_pkg::NIBS; i++) begin
            t_mask[i] = !cfg_i.transp ||
                        (val_s_q[i*blit_pkg::NIB_W +: blit_pkg::NIB_W] !=
                         cfg_i.transp_t[(i%2)*blit_pkg::NIB_W +: blit_pkg::NIB_W]);
        end
    end

    assign f_sel = first_word_i ? cfg_i.f_mask : '1;
    assign l_sel = last_word_i  ? cfg_i.l_mask : '1;

    assign data_o    = cfg_i.c_and ? (val_s_q & cfg_i.val_c) : (val_s_q ^ cfg_i.val_c);
    assign wr_mask_o = f_sel & l_sel & t_mask;

endmodule

`default_nettype wire

//--- blit_engine.sv
`default_nettype none

module blit_engine #(
    parameter int ADDR_W = 16
) (
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire logic                 full_i,           // a blit is queued
    input  wire blit_pkg::blit_cfg_t  cfg_i,            // active cfg
    input  wire logic                 vram_ack_i,
    output      logic                 setup_o,
    output      logic                 busy_o,
    output      logic                 done_o,
    output      logic                 sel_o,
    output      logic                 wr_o,
    output      logic [ADDR_W-1:0]    addr_o,
    output      logic                 capture_o,        // source word present on vram data
    output      logic                 first_word_o,
    output      logic                 last_word_o
);

    localparam int CNT_W = blit_pkg::WORD_W + 1;        // msb is the underflow flag

    blit_pkg::blit_state_e state_q, state_d;

    logic              sel_q, sel_d;
    logic              wr_q, wr_d;
    logic              done_q;
    logic              first_q, first_d;
    logic              new_blit_q, new_blit_d;          // first LINE_BEG loads from cfg
    logic [CNT_W-1:0]  count_q, count_d;                // words left in line
    logic [CNT_W-1:0]  lines_q, lines_d;                // lines left in blit
    logic [ADDR_W-1:0] addr_q, addr_d;
    logic [ADDR_W-1:0] src_q, src_d;
    logic [ADDR_W-1:0] dst_q, dst_d;

    logic              advance;
    logic              last_word;
    logic              last_line;
    logic [ADDR_W-1:0] src_base;
    logic [ADDR_W-1:0] dst_base;
    logic [CNT_W-1:0]  lines_base;

    assign advance   = !sel_q || vram_ack_i;            // hold everything while an access waits
    assign last_word = count_q[CNT_W-1];
    assign last_line = lines_q[CNT_W-1];

    // active cfg only becomes valid in the cycle after SETUP
    assign src_base   = new_blit_q ? ADDR_W'(cfg_i.src_s) : src_q;
    assign dst_base   = new_blit_q ? ADDR_W'(cfg_i.dst_d) : dst_q;
    assign lines_base = new_blit_q ? {1'b0, cfg_i.lines} : lines_q;

    always_comb begin
        state_d    = state_q;
        sel_d      = 1'b0;
        wr_d       = 1'b0;
        addr_d     = addr_q;
        src_d      = src_q;
        dst_d      = dst_q;
        count_d    = count_q;
        lines_d    = lines_q;
        first_d    = first_q;
        new_blit_d = new_blit_q;
        setup_o    = 1'b0;

        case (state_q)
            blit_pkg::IDLE: begin
                if (full_i) begin
                    state_d = blit_pkg::SETUP;
                end
            end
            blit_pkg::SETUP: begin
                setup_o    = 1'b1;
                new_blit_d = 1'b1;
                state_d    = blit_pkg::LINE_BEG;
            end
            blit_pkg::LINE_BEG: begin
                new_blit_d = 1'b0;
                first_d    = 1'b1;
                lines_d    = lines_base - 1'b1;                 // underflow marks the last line
                count_d    = {1'b0, cfg_i.words} - 1'b1;        // underflow marks the last word
                src_d      = src_base;
                dst_d      = dst_base;
                sel_d      = 1'b1;
                if (cfg_i.s_const) begin
                    wr_d    = 1'b1;
                    addr_d  = dst_base;
                    state_d = blit_pkg::WR_D;
                end else begin
                    addr_d  = src_base;
                    state_d = blit_pkg::RD_S;
                end
            end
            blit_pkg::RD_S: begin
                src_d   = addr_q + 1'b1;
                sel_d   = 1'b1;
                wr_d    = 1'b1;
                addr_d  = dst_q;
                state_d = blit_pkg::WR_D;
            end
            blit_pkg::WR_D: begin
                dst_d   = addr_q + 1'b1;
                addr_d  = addr_q + 1'b1;                        // next dest for constant runs
                count_d = count_q - 1'b1;
                first_d = 1'b0;
                if (last_word) begin
                    state_d = blit_pkg::LINE_END;
                end else if (!cfg_i.s_const) begin
                    sel_d   = 1'b1;
                    addr_d  = src_q;
                    state_d = blit_pkg::RD_S;
                end else begin
                    sel_d   = 1'b1;
                    wr_d    = 1'b1;
                    state_d = blit_pkg::WR_D;
                end
            end
            blit_pkg::LINE_END: begin
                src_d = src_q + ADDR_W'(cfg_i.mod_s);
                dst_d = dst_q + ADDR_W'(cfg_i.mod_d);
                if (!last_line) begin
                    state_d = blit_pkg::LINE_BEG;
                end else if (full_i) begin
                    state_d = blit_pkg::SETUP;                  // back to back, busy stays high
                end else begin
                    state_d = blit_pkg::IDLE;
                end
            end
            default: begin
                state_d = blit_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= blit_pkg::IDLE;
            sel_q      <= 1'b0;
            wr_q       <= 1'b0;
            done_q     <= 1'b0;
            first_q    <= 1'b0;
            new_blit_q <= 1'b0;
            count_q    <= '0;
            lines_q    <= '0;
        end else begin
            done_q <= (state_q == blit_pkg::LINE_END) && last_line;
            if (advance) begin
                state_q    <= state_d;
                sel_q      <= sel_d;
                wr_q       <= wr_d;
                first_q    <= first_d;
                new_blit_q <= new_blit_d;
                count_q    <= count_d;
                lines_q    <= lines_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            addr_q <= addr_d;
            src_q  <= src_d;
            dst_q  <= dst_d;
        end
    end

    assign busy_o       = (state_q != blit_pkg::IDLE);
    assign done_o       = done_q;
    assign sel_o        = sel_q;
    assign wr_o         = wr_q;
    assign addr_o       = addr_q;
    assign capture_o    = (state_q == blit_pkg::RD_S) && vram_ack_i;
    assign first_word_o = first_q;
    assign last_word_o  = last_word;

endmodule

`default_nettype wire

//--- blit_pkg.sv
`default_nettype none

package blit_pkg;

    localparam int WORD_W = 16;                 // vram data word
    localparam int NIB_W  = 4;                  // shifter and mask granularity
    localparam int NIBS   = WORD_W / NIB_W;     // nibbles per word, one mask bit each

    typedef logic [WORD_W-1:0] word_t;

    // host register numbers
    typedef enum logic [3:0] {
        CTRL  = 4'd0,       // s_const, c_and, transp, transp_t
        VAL_C = 4'd1,       // logic op constant
        MOD_S = 4'd2,       // source end of line modulo
        SRC_S = 4'd3,       // source address or constant value
        MOD_D = 4'd4,       // dest end of line modulo
        DST_D = 4'd5,       // dest address
        SHIFT = 4'd6,       // f_mask, l_mask, shift_amt
        LINES = 4'd7,       // line count minus 1
        WORDS = 4'd8        // words per line minus 1, queues the blit
    } blit_reg_e;

    typedef enum logic [2:0] {
        IDLE,               // wait for a queued blit
        SETUP,              // take queued cfg into the active copy
        LINE_BEG,           // load counters, start first access of line
        RD_S,               // source read
        WR_D,               // dest write
        LINE_END            // add modulos, next line or finish
    } blit_state_e;

    typedef struct packed {
        logic            s_const;       // source is src_s itself
        logic            c_and;         // AND with val_c, else XOR
        logic            transp;        // 4-bit transparency enable
        logic [7:0]      transp_t;      // transparent nibble pair
        logic [1:0]      shift_amt;     // right shift in nibbles
        logic [NIBS-1:0] f_mask;        // first word of line
        logic [NIBS-1:0] l_mask;        // last word of line
        word_t           val_c;
        word_t           mod_s;
        word_t           src_s;
        word_t           mod_d;
        word_t           dst_d;
        word_t           lines;
        word_t           words;
    } blit_cfg_t;

    typedef struct packed {
        logic            sel;
        logic            wr;
        logic [NIBS-1:0] wr_mask;       // one bit per nibble
        word_t           addr;
        word_t           data;
    } vram_req_t;

endpackage

`default_nettype wire

//--- blit_regs.sv
`default_nettype none

module blit_regs (
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire logic                 reg_wr_i,
    input  wire blit_pkg::blit_reg_e  reg_num_i,
    input  wire blit_pkg::word_t      reg_data_i,
    input  wire logic                 setup_i,          // engine takes the queued blit
    output      logic                 full_o,
    output      blit_pkg::blit_cfg_t  active_cfg_o
);

    blit_pkg::blit_cfg_t queued_q;                      // next blit, loaded by the host
    blit_pkg::blit_cfg_t active_q;                      // blit in progress
    logic                queued_flag_q;

    // host writes land in the queued copy only
    always_ff @(posedge clk) begin
        if (reset_i) begin
            queued_q      <= '0;
            queued_flag_q <= 1'b0;
        end else begin
            if (setup_i) begin
                queued_flag_q <= 1'b0;
            end

            if (reg_wr_i) begin
                case (reg_num_i)
                    blit_pkg::CTRL: begin
                        queued_q.transp_t <= reg_data_i[15:8];
                        queued_q.transp   <= reg_data_i[4];
                        queued_q.c_and    <= reg_data_i[1];
                        queued_q.s_const  <= reg_data_i[0];
                    end
                    blit_pkg::VAL_C: begin
                        queued_q.val_c <= reg_data_i;
                    end
                    blit_pkg::MOD_S: begin
                        queued_q.mod_s <= reg_data_i;
                    end
                    blit_pkg::SRC_S: begin
                        queued_q.src_s <= reg_data_i;
                    end
                    blit_pkg::MOD_D: begin
                        queued_q.mod_d <= reg_data_i;
                    end
                    blit_pkg::DST_D: begin
                        queued_q.dst_d <= reg_data_i;
                    end
                    blit_pkg::SHIFT: begin
                        queued_q.f_mask    <= reg_data_i[15:12];
                        queued_q.l_mask    <= reg_data_i[11:8];
                        queued_q.shift_amt <= reg_data_i[1:0];
                    end
                    blit_pkg::LINES: begin
                        queued_q.lines <= reg_data_i;
                    end
                    blit_pkg::WORDS: begin
                        queued_q.words <= reg_data_i;
                        queued_flag_q  <= 1'b1;         // wins over a same-cycle setup
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // active copy, valid the cycle after setup
    always_ff @(posedge clk) begin
        if (reset_i) begin
            active_q <= '0;
        end else if (setup_i) begin
            active_q <= queued_q;
        end
    end

    assign full_o       = queued_flag_q;
    assign active_cfg_o = active_q;

endmodule

`default_nettype wire

//--- blitter.f
blit_pkg.sv
blit_regs.sv
blit_engine.sv
blit_datapath.sv
blitter_top.sv
blitter_checker.sv
tb_vram_model.sv
tb_blitter.sv

//--- blitter_checker.sv
`default_nettype none

module blitter_checker (
    input wire logic                clk,
    input wire logic                reset_i,
    input wire blit_pkg::vram_req_t req_i,
    input wire logic                ack_i,
    input wire logic                full_i,
    input wire logic                done_i
);

    timeunit 1ns;
    timeprecision 100ps;

    logic        seen_full_q;                           // a blit was queued since reset
    int unsigned fail_count = 0;                        // failed assertions so far

    always_ff @(posedge clk) begin
        if (reset_i) begin
            seen_full_q <= 1'b0;
        end else if (full_i) begin
            seen_full_q <= 1'b1;
        end
    end

    sel_after_full: assert property (@(posedge clk) disable iff (reset_i)
        req_i.sel |-> seen_full_q)
        else begin
            fail_count = fail_count + 1;
            $error("vram select before any blit was queued");
        end

    req_held: assert property (@(posedge clk) disable iff (reset_i)
        req_i.sel && !ack_i |=> req_i.sel && $stable(req_i.addr) && $stable(req_i.wr))
        else begin
            fail_count = fail_count + 1;
            $error("vram request changed before ack");
        end

    done_pulse: assert property (@(posedge clk) disable iff (reset_i)
        done_i |=> !done_i)
        else begin
            fail_count = fail_count + 1;
            $error("done held longer than one cycle");
        end

    wr_needs_sel: assert property (@(posedge clk) disable iff (reset_i)
        req_i.wr |-> req_i.sel)
        else begin
            fail_count = fail_count + 1;
            $error("vram write strobe without select");
        end

endmodule

`default_nettype wire

//--- blitter_top.sv
`default_nettype none

module blitter_top #(
    parameter int ADDR_W = 16                           // vram word address width
) (
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire logic                 reg_wr_i,
    input  wire blit_pkg::blit_reg_e  reg_num_i,
    input  wire blit_pkg::word_t      reg_data_i,
    output      blit_pkg::vram_req_t  vram_req_o,
    input  wire logic                 vram_ack_i,
    input  wire blit_pkg::word_t      vram_data_i,
    output      logic                 busy_o,
    output      logic                 full_o,
    output      logic                 done_o
);

    blit_pkg::blit_cfg_t       active_cfg;
    logic                      setup;
    logic                      sel;
    logic                      wr;
    logic [ADDR_W-1:0]         addr;
    logic                      capture;
    logic                      first_word;
    logic                      last_word;
    blit_pkg::word_t           wr_data;
    logic [blit_pkg::NIBS-1:0] wr_mask;

    blit_regs i_regs (
        .clk          (clk),
        .reset_i      (reset_i),
        .reg_wr_i     (reg_wr_i),
        .reg_num_i    (reg_num_i),
        .reg_data_i   (reg_data_i),
        .setup_i      (setup),
        .full_o       (full_o),
        .active_cfg_o (active_cfg)
    );

    blit_engine #(
        .ADDR_W (ADDR_W)
    ) i_engine (
        .clk          (clk),
        .reset_i      (reset_i),
        .full_i       (full_o),
        .cfg_i        (active_cfg),
        .vram_ack_i   (vram_ack_i),
        .setup_o      (setup),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .sel_o        (sel),
        .wr_o         (wr),
        .addr_o       (addr),
        .capture_o    (capture),
        .first_word_o (first_word),
        .last_word_o  (last_word)
    );

    blit_datapath i_datapath (
        .clk          (clk),
        .reset_i      (reset_i),
        .cfg_i        (active_cfg),
        .setup_i      (setup),
        .capture_i    (capture),
        .vram_data_i  (vram_data_i),
        .first_word_i (first_word),
        .last_word_i  (last_word),
        .data_o       (wr_data),
        .wr_mask_o    (wr_mask)
    );

    assign vram_req_o.sel     = sel;
    assign vram_req_o.wr      = wr;
    assign vram_req_o.wr_mask = wr_mask;
    assign vram_req_o.addr    = blit_pkg::word_t'(addr);
    assign vram_req_o.data    = wr_data;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the blitter testbench with Verilator

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_blitter --Mdir obj_dir -o tb_blitter -f blitter.f > build.log 2>&1 &&
    ./obj_dir/tb_blitter > sim.log 2>&1 ||
    { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "CHECKS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"

//--- tb_blitter.sv
`default_nettype none

module tb_blitter;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_ROWS   = 11;
    localparam int N_SINGLE = 9;                        // rows run alone before the queued pair
    localparam int Q_A      = 9;
    localparam int Q_B      = 10;
    localparam int TIMEOUT  = 5000;                     // cycles per wait

    // column order CTRL, VAL_C, MOD_S, SRC_S, MOD_D, DST_D, SHIFT, LINES, WORDS
    blit_pkg::word_t regs_tab [N_ROWS][9] = '{
        '{16'h0000, 16'h0000, 16'h0004, 16'h0100, 16'h0008, 16'h0400, 16'hff00, 16'h0002, 16'h0003},
        '{16'h0000, 16'h0000, 16'h0002, 16'h0140, 16'h0003, 16'h0480, 16'hff01, 16'h0001, 16'h0004},
        '{16'h0000, 16'h0000, 16'h0001, 16'h0180, 16'h0006, 16'h04c0, 16'h3e02, 16'h0002, 16'h0002},
        '{16'h0000, 16'h0000, 16'h0003, 16'h01c0, 16'h0005, 16'h0500, 16'he703, 16'h0003, 16'h0000},
        '{16'h0001, 16'h0000, 16'h0000, 16'hbeef, 16'h0005, 16'h0540, 16'hff00, 16'h0002, 16'h0005},
        '{16'h0003, 16'h0ff0, 16'h0000, 16'h1234, 16'h0002, 16'h0580, 16'hff00, 16'h0001, 16'h0003},
        '{16'h0002, 16'hf0f0, 16'h0000, 16'h0200, 16'h0000, 16'h05c0, 16'hff01, 16'h0001, 16'h0003},
        '{16'h3c11, 16'h0000, 16'h0000, 16'h3a3c, 16'h0002, 16'h0600, 16'hff00, 16'h0001, 16'h0003},
        '{16'h5a10, 16'h00ff, 16'h0001, 16'h0240, 16'h0001, 16'h0640, 16'hff01, 16'h0002, 16'h0006},
        '{16'h0000, 16'h1234, 16'h0008, 16'h1000, 16'h0008, 16'h2000, 16'hff02, 16'h0007, 16'h0007},
        '{16'h0001, 16'h0000, 16'h0000, 16'h5ca1, 16'h0004, 16'h3000, 16'h7e00, 16'h0003, 16'h0003}
    };
    string name_tab [N_ROWS] = '{
        "copy_plain", "shift_1", "shift_2_masks", "shift_3_one_word", "const_fill",
        "const_and", "src_and", "transp_const", "transp_copy", "queue_a", "queue_b"
    };

    logic                clk;
    logic                reset;
    logic                reg_wr;
    blit_pkg::blit_reg_e reg_num;
    blit_pkg::word_t     reg_data;
    blit_pkg::vram_req_t vram_req;
    logic                vram_ack;
    blit_pkg::word_t     vram_data;
    logic                busy;
    logic                full;
    logic                done;
    logic                fill;
    blit_pkg::word_t     fill_salt;

    blit_pkg::word_t     exp_mem [0:65535];              // expected vram contents
    int                  n_checks;
    int                  errors;
    int                  timeouts;
    logic                timed_out;

    blitter_top #(
        .ADDR_W (16)
    ) i_dut (
        .clk         (clk),
        .reset_i     (reset),
        .reg_wr_i    (reg_wr),
        .reg_num_i   (reg_num),
        .reg_data_i  (reg_data),
        .vram_req_o  (vram_req),
        .vram_ack_i  (vram_ack),
        .vram_data_i (vram_data),
        .busy_o      (busy),
        .full_o      (full),
        .done_o      (done)
    );

    tb_vram_model i_vram (
        .clk     (clk),
        .reset_i (reset),
        .fill_i  (fill),
        .salt_i  (fill_salt),
        .req_i   (vram_req),
        .ack_o   (vram_ack),
        .data_o  (vram_data)
    );

    bind blitter_top blitter_checker i_checker (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (vram_req_o),
        .ack_i   (vram_ack_i),
        .full_i  (full_o),
        .done_i  (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic fill_memory(input int t);
        @(posedge clk);
        fill      <= 1'b1;
        fill_salt <= blit_pkg::word_t'(t * 4369);
        @(posedge clk);
        fill      <= 1'b0;
        @(negedge clk);
        for (int a = 0; a < 65536; a++) begin
            exp_mem[a] = i_vram.mem[a];
        end
    endtask

    // line by line walk of one blit over the expected memory
    task automatic apply_model(input int t, output int reads);
        blit_pkg::word_t ctrl;
        blit_pkg::word_t shift;
        blit_pkg::word_t src;
        blit_pkg::word_t dst;
        blit_pkg::word_t prev;
        blit_pkg::word_t val;
        blit_pkg::word_t res;
        logic [31:0]     joined;
        logic [3:0]      mask;
        int              n_lines;
        int              n_words;
        ctrl    = regs_tab[t][0];
        shift   = regs_tab[t][6];
        src     = regs_tab[t][3];
        dst     = regs_tab[t][5];
        prev    = '0;                                   // every blit starts without carry
        n_lines = int'(regs_tab[t][7]) + 1;
        n_words = int'(regs_tab[t][8]) + 1;
        reads   = ctrl[0] ? 0 : n_lines * n_words;
        for (int ln = 0; ln < n_lines; ln++) begin
            for (int w = 0; w < n_words; w++) begin
                if (ctrl[0]) begin
                    val = regs_tab[t][3];
                end else begin
                    joined = {prev, exp_mem[src]} >> (4 * shift[1:0]);
                    val    = joined[15:0];
                    prev   = exp_mem[src];
                    src    = src + 16'd1;
                end
                res  = ctrl[1] ? (val & regs_tab[t][1]) : (val ^ regs_tab[t][1]);
                mask = 4'hf;
                if (w == 0) begin
                    mask = mask & shift[15:12];
                end
                if (w == n_words - 1) begin
                    mask = mask & shift[11:8];
                end
                for (int i = 0; i < 4; i++) begin
                    if (ctrl[4] && val[4*i +: 4] == ctrl[8 + 4*(i%2) +: 4]) begin
                        mask[i] = 1'b0;                 // transparent nibble
                    end
                    if (mask[i]) begin
                        exp_mem[dst][4*i +: 4] = res[4*i +: 4];
                    end
                end
                dst = dst + 16'd1;
            end
            src = src + regs_tab[t][2];
            dst = dst + regs_tab[t][4];
        end
    endtask

    task automatic write_blit(input int t);
        for (int r = 0; r < 9; r++) begin
            @(posedge clk);
            reg_wr   <= 1'b1;
            reg_num  <= blit_pkg::blit_reg_e'(r);       // WORDS goes last
            reg_data <= regs_tab[t][r];
        end
        @(posedge clk);
        reg_wr <= 1'b0;
        @(negedge clk);
        check({name_tab[t], " full set"}, 32'd1, 32'(full));
    endtask

    task automatic wait_done(input int t);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!done && cycles < TIMEOUT);
        if (!done) begin
            timeouts++;
            timed_out = 1'b1;
            $display("timeout: %s never raised done within %0d cycles", name_tab[t], TIMEOUT);
        end
    endtask

    task automatic wait_full_low(input int t);
        int cycles;
        cycles = 0;
        while (full && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (full) begin
            timeouts++;
            timed_out = 1'b1;
            $display("timeout: queued blit %s was never taken", name_tab[t]);
        end
    endtask

    task automatic compare_mem(input int t);
        for (int a = 0; a < 65536; a++) begin
            check($sformatf("%s mem[%04h]", name_tab[t], a),
                  32'(exp_mem[a]), 32'(i_vram.mem[a]));
        end
    endtask

    task automatic run_single(input int t);
        int exp_reads;
        fill_memory(t);
        apply_model(t, exp_reads);
        write_blit(t);
        wait_done(t);
        if (!timed_out) begin
            check({name_tab[t], " busy at done"}, 32'd0, 32'(busy));
            check({name_tab[t], " full at done"}, 32'd0, 32'(full));
            check({name_tab[t], " reads"}, 32'(exp_reads), 32'(i_vram.rd_count));
            compare_mem(t);
        end
    endtask

    // second blit loaded while the first one runs
    task automatic run_queue();
        int reads_a;
        int reads_b;
        fill_memory(Q_A);
        apply_model(Q_A, reads_a);
        apply_model(Q_B, reads_b);
        write_blit(Q_A);
        wait_full_low(Q_A);
        if (timed_out) begin
            return;
        end
        check("queue_a busy", 32'd1, 32'(busy));
        write_blit(Q_B);
        check("queue_b busy while queued", 32'd1, 32'(busy));
        wait_done(Q_A);
        if (timed_out) begin
            return;
        end
        check("queue_a busy at done", 32'd1, 32'(busy));      // straight into SETUP
        check("queue_a full at done", 32'd1, 32'(full));
        wait_full_low(Q_B);
        if (timed_out) begin
            return;
        end
        wait_done(Q_B);
        if (timed_out) begin
            return;
        end
        check("queue_b busy at done", 32'd0, 32'(busy));
        check("queue_b full at done", 32'd0, 32'(full));
        check("queue reads", 32'(reads_a + reads_b), 32'(i_vram.rd_count));
        compare_mem(Q_B);
    endtask

    initial begin
        void'($urandom(32'h5e38_5135));
        reset     = 1'b1;
        reg_wr    = 1'b0;
        reg_num   = blit_pkg::CTRL;
        reg_data  = '0;
        fill      = 1'b0;
        fill_salt = '0;
        n_checks  = 0;
        errors    = 0;
        timeouts  = 0;
        timed_out = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check("reset busy", 32'd0, 32'(busy));
        check("reset full", 32'd0, 32'(full));
        check("reset done", 32'd0, 32'(done));

        for (int t = 0; t < N_SINGLE && !timed_out; t++) begin
            run_single(t);
        end
        if (!timed_out) begin
            run_queue();
        end

        check("assertion failures", 32'd0, 32'(i_dut.i_checker.fail_count));
        $display("checks: %0d  errors: %0d  timeouts: %0d", n_checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_vram_model.sv
`default_nettype none

module tb_vram_model (
    input  wire logic                clk,
    input  wire logic                reset_i,
    input  wire logic                fill_i,            // load the address pattern
    input  wire blit_pkg::word_t     salt_i,
    input  wire blit_pkg::vram_req_t req_i,
    output      logic                ack_o,
    output      blit_pkg::word_t     data_o
);

    timeunit 1ns;
    timeprecision 100ps;

    blit_pkg::word_t mem [0:65535];
    logic [1:0]      delay_q;                           // wait cycles for this access
    logic [1:0]      wait_q;
    int unsigned     rd_count;                          // reads since the last fill

    assign ack_o  = req_i.sel && (wait_q == delay_q);
    assign data_o = mem[req_i.addr];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            delay_q  <= 2'd0;
            wait_q   <= 2'd0;
            rd_count <= 0;
        end else if (fill_i) begin
            // odd multiplier keeps every address distinct
            for (int a = 0; a < 65536; a++) begin
                mem[a] <= blit_pkg::word_t'(a * 40503) ^ salt_i;
            end
            rd_count <= 0;
        end else if (ack_o) begin
            if (req_i.wr) begin
                for (int i = 0; i < blit_pkg::NIBS; i++) begin
                    if (req_i.wr_mask[i]) begin
                        mem[req_i.addr][i*blit_pkg::NIB_W +: blit_pkg::NIB_W] <=
                            req_i.data[i*blit_pkg::NIB_W +: blit_pkg::NIB_W];
                    end
                end
            end else begin
                rd_count <= rd_count + 1;
            end
            wait_q  <= 2'd0;
            delay_q <= 2'($urandom % 4);                // delay of the next access
        end else if (req_i.sel) begin
            wait_q <= wait_q + 2'd1;
        end
    end

endmodule

`default_nettype wire
